// ==== Bender.yml ====
package:
  name: processorci_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/processorci_pkg.sv
      - hw/axi_resp_fifo.sv
      - hw/axi4_to_wishbone.sv
      - hw/processorci_top.sv
      - target: test
        files:
          - test/wb_mem_model.sv
          - test/tb_processorci_top.sv

// ==== hw/axi4_to_wishbone.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "processorci_macros.svh"

module axi4_to_wishbone (
    input  wire logic                     clk,
    input  wire logic                     rst_i,

    // Write address
    input  wire processorci_pkg::axi_aw_t aw_i,
    input  wire logic                     aw_valid_i,
    output logic                          aw_ready_o,

    // Write data
    input  wire processorci_pkg::axi_w_t  w_i,
    input  wire logic                     w_valid_i,
    output logic                          w_ready_o,

    // Write response
    output processorci_pkg::axi_b_t       b_o,
    output logic                          b_valid_o,
    input  wire logic                     b_ready_i,

    // Read address
    input  wire processorci_pkg::axi_ar_t ar_i,
    input  wire logic                     ar_valid_i,
    output logic                          ar_ready_o,

    // Read data
    output processorci_pkg::axi_r_t       r_o,
    output logic                          r_valid_o,
    input  wire logic                     r_ready_i,

    // Wishbone classic master
    output processorci_pkg::wb_req_t      wb_req_o,
    input  wire processorci_pkg::wb_rsp_t wb_rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } state_e;

    state_e state_q;
    logic   last_wr_q;  // Set when the last grant went to a write

    // Request held for the whole Wishbone cycle
    logic [`PCI_ID_W-1:0]   req_id_q;
    logic [`PCI_ADDR_W-1:0] req_addr_q;
    logic [`PCI_DATA_W-1:0] req_wdata_q;
    logic [`PCI_STRB_W-1:0] req_sel_q;

    logic wr_elig;
    logic rd_elig;
    logic wr_grant;
    logic rd_grant;
    logic b_full;
    logic r_full;
    logic b_push;
    logic r_push;

    processorci_pkg::axi_b_t b_push_data;
    processorci_pkg::axi_r_t r_push_data;

    // A write needs both AW and W, and room for its response
    assign wr_elig = (state_q == ST_IDLE) && aw_valid_i && w_valid_i && !b_full;
    assign rd_elig = (state_q == ST_IDLE) && ar_valid_i && !r_full;

    // Alternate on contention, write first after reset
    assign wr_grant = wr_elig && (!rd_elig || !last_wr_q);
    assign rd_grant = rd_elig && !wr_grant;

    assign aw_ready_o = wr_grant;
    assign w_ready_o  = wr_grant;  // AW and W always taken together
    assign ar_ready_o = rd_grant;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            last_wr_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_grant) begin
                        state_q   <= ST_WRITE;
                        last_wr_q <= 1'b1;
                    end else if (rd_grant) begin
                        state_q   <= ST_READ;
                        last_wr_q <= 1'b0;
                    end
                end
                ST_WRITE, ST_READ: begin
                    // Slave latency ends with ack, stb drops next cycle
                    if (wb_rsp_i.ack) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Capture on acceptance
    always_ff @(posedge clk) begin
        if (wr_grant) begin
            req_id_q    <= aw_i.id;
            req_addr_q  <= aw_i.addr;
            req_wdata_q <= w_i.data;
            req_sel_q   <= w_i.strb;
        end else if (rd_grant) begin
            req_id_q   <= ar_i.id;
            req_addr_q <= ar_i.addr;
            req_sel_q  <= {`PCI_STRB_W{1'b1}};  // Full word read
        end
    end

    always_comb begin
        wb_req_o       = '0;
        wb_req_o.cyc   = (state_q != ST_IDLE);
        wb_req_o.stb   = (state_q != ST_IDLE);
        wb_req_o.we    = (state_q == ST_WRITE);
        wb_req_o.sel   = req_sel_q;
        wb_req_o.addr  = req_addr_q;
        wb_req_o.wdata = req_wdata_q;
    end

    // Response goes to the FIFO on the ack edge
    assign b_push = (state_q == ST_WRITE) && wb_rsp_i.ack;
    assign r_push = (state_q == ST_READ) && wb_rsp_i.ack;

    always_comb begin
        b_push_data.id   = req_id_q;
        b_push_data.resp = processorci_pkg::AXI_RESP_OKAY;
        r_push_data.id   = req_id_q;
        r_push_data.data = wb_rsp_i.rdata;
        r_push_data.resp = processorci_pkg::AXI_RESP_OKAY;
    end

    axi_resp_fifo #(
        .payload_t   (processorci_pkg::axi_b_t),
        .DEPTH       (`PCI_RESP_DEPTH)
    ) u_b_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (b_push),
        .push_data_i (b_push_data),
        .pop_ready_i (b_ready_i),
        .full_o      (b_full),
        .pop_valid_o (b_valid_o),
        .pop_data_o  (b_o)
    );

    axi_resp_fifo #(
        .payload_t   (processorci_pkg::axi_r_t),
        .DEPTH       (`PCI_RESP_DEPTH)
    ) u_r_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (r_push),
        .push_data_i (r_push_data),
        .pop_ready_i (r_ready_i),
        .full_o      (r_full),
        .pop_valid_o (r_valid_o),
        .pop_data_o  (r_o)
    );

endmodule

`default_nettype wire

// ==== hw/axi_resp_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "processorci_macros.svh"

module axi_resp_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `PCI_RESP_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     rst_i,
    input  wire logic     push_i,
    input  wire payload_t push_data_i,
    input  wire logic     pop_ready_i,
    output logic          full_o,
    output logic          pop_valid_o,
    output payload_t      pop_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];  // Storage only, no reset
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pop_valid_o = (count_q != '0);
    assign full_o      = (count_q == CNT_W'(DEPTH));
    assign do_pop      = pop_valid_o && pop_ready_i;
    assign do_push     = push_i && (!full_o || do_pop);  // Full slot frees on a pop
    assign pop_data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/processorci_pkg.sv ====
`default_nettype none

`include "processorci_macros.svh"

package processorci_pkg;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;  // Only response code produced

    // Write address channel, single beat so no len/burst
    typedef struct packed {
        logic [`PCI_ID_W-1:0]   id;
        logic [`PCI_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [`PCI_DATA_W-1:0] data;
        logic [`PCI_STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [`PCI_ID_W-1:0]   id;
        logic [`PCI_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [`PCI_ID_W-1:0] id;
        logic [1:0]           resp;
    } axi_b_t;

    // Read data, last is implied
    typedef struct packed {
        logic [`PCI_ID_W-1:0]   id;
        logic [`PCI_DATA_W-1:0] data;
        logic [1:0]             resp;
    } axi_r_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`PCI_STRB_W-1:0] sel;
        logic [`PCI_ADDR_W-1:0] addr;
        logic [`PCI_DATA_W-1:0] wdata;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`PCI_DATA_W-1:0] rdata;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/processorci_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module processorci_top (
    input  wire logic                     sys_clk,
    input  wire logic                     rst_i,

    // Instruction port, AXI from the core
    input  wire processorci_pkg::axi_aw_t axi_i_aw_i,
    input  wire logic                     axi_i_aw_valid_i,
    output logic                          axi_i_aw_ready_o,
    input  wire processorci_pkg::axi_w_t  axi_i_w_i,
    input  wire logic                     axi_i_w_valid_i,
    output logic                          axi_i_w_ready_o,
    output processorci_pkg::axi_b_t       axi_i_b_o,
    output logic                          axi_i_b_valid_o,
    input  wire logic                     axi_i_b_ready_i,
    input  wire processorci_pkg::axi_ar_t axi_i_ar_i,
    input  wire logic                     axi_i_ar_valid_i,
    output logic                          axi_i_ar_ready_o,
    output processorci_pkg::axi_r_t       axi_i_r_o,
    output logic                          axi_i_r_valid_o,
    input  wire logic                     axi_i_r_ready_i,
    output processorci_pkg::wb_req_t      core_wb_req_o,
    input  wire processorci_pkg::wb_rsp_t core_wb_rsp_i,

    // Data port
    input  wire processorci_pkg::axi_aw_t axi_d_aw_i,
    input  wire logic                     axi_d_aw_valid_i,
    output logic                          axi_d_aw_ready_o,
    input  wire processorci_pkg::axi_w_t  axi_d_w_i,
    input  wire logic                     axi_d_w_valid_i,
    output logic                          axi_d_w_ready_o,
    output processorci_pkg::axi_b_t       axi_d_b_o,
    output logic                          axi_d_b_valid_o,
    input  wire logic                     axi_d_b_ready_i,
    input  wire processorci_pkg::axi_ar_t axi_d_ar_i,
    input  wire logic                     axi_d_ar_valid_i,
    output logic                          axi_d_ar_ready_o,
    output processorci_pkg::axi_r_t       axi_d_r_o,
    output logic                          axi_d_r_valid_o,
    input  wire logic                     axi_d_r_ready_i,
    output processorci_pkg::wb_req_t      data_mem_wb_req_o,
    input  wire processorci_pkg::wb_rsp_t data_mem_wb_rsp_i
);

    // Instruction fetch path
    axi4_to_wishbone u_instr_bridge (
        .clk        (sys_clk),
        .rst_i      (rst_i),
        .aw_i       (axi_i_aw_i),
        .aw_valid_i (axi_i_aw_valid_i),
        .aw_ready_o (axi_i_aw_ready_o),
        .w_i        (axi_i_w_i),
        .w_valid_i  (axi_i_w_valid_i),
        .w_ready_o  (axi_i_w_ready_o),
        .b_o        (axi_i_b_o),
        .b_valid_o  (axi_i_b_valid_o),
        .b_ready_i  (axi_i_b_ready_i),
        .ar_i       (axi_i_ar_i),
        .ar_valid_i (axi_i_ar_valid_i),
        .ar_ready_o (axi_i_ar_ready_o),
        .r_o        (axi_i_r_o),
        .r_valid_o  (axi_i_r_valid_o),
        .r_ready_i  (axi_i_r_ready_i),
        .wb_req_o   (core_wb_req_o),
        .wb_rsp_i   (core_wb_rsp_i)
    );

    // Load/store path, own memory bus
    axi4_to_wishbone u_data_bridge (
        .clk        (sys_clk),
        .rst_i      (rst_i),
        .aw_i       (axi_d_aw_i),
        .aw_valid_i (axi_d_aw_valid_i),
        .aw_ready_o (axi_d_aw_ready_o),
        .w_i        (axi_d_w_i),
        .w_valid_i  (axi_d_w_valid_i),
        .w_ready_o  (axi_d_w_ready_o),
        .b_o        (axi_d_b_o),
        .b_valid_o  (axi_d_b_valid_o),
        .b_ready_i  (axi_d_b_ready_i),
        .ar_i       (axi_d_ar_i),
        .ar_valid_i (axi_d_ar_valid_i),
        .ar_ready_o (axi_d_ar_ready_o),
        .r_o        (axi_d_r_o),
        .r_valid_o  (axi_d_r_valid_o),
        .r_ready_i  (axi_d_r_ready_i),
        .wb_req_o   (data_mem_wb_req_o),
        .wb_rsp_i   (data_mem_wb_rsp_i)
    );

endmodule

`default_nettype wire

// ==== include/processorci_macros.svh ====
`ifndef PROCESSORCI_MACROS_SVH
`define PROCESSORCI_MACROS_SVH

// Bus widths shared by both core ports
`define PCI_ADDR_W     32
`define PCI_DATA_W     32
`define PCI_ID_W       4
`define PCI_STRB_W     (`PCI_DATA_W / 8)  // One strobe per byte lane

// Response buffering per channel
`define PCI_RESP_DEPTH 2

`endif

// ==== list.f ====
+incdir+include
hw/processorci_pkg.sv
hw/axi_resp_fifo.sv
hw/axi4_to_wishbone.sv
hw/processorci_top.sv
test/wb_mem_model.sv
test/tb_processorci_top.sv

// ==== test/tb_processorci_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_processorci_top;

    // About 25 transactions of under 20 cycles each, plus reset and drain
    localparam int MAX_CYCLES = 4000;
    localparam int SEED       = 36986;

    logic clk;
    logic rst;
    int   cycles = 0;

    processorci_pkg::axi_aw_t      aw [2];
    processorci_pkg::axi_w_t       w [2];
    processorci_pkg::axi_ar_t      ar [2];
    wire processorci_pkg::axi_b_t  b [2];
    wire processorci_pkg::axi_r_t  r [2];
    wire processorci_pkg::wb_req_t wb_req [2];
    wire processorci_pkg::wb_rsp_t wb_rsp [2];

    logic [1:0] aw_valid;
    logic [1:0] w_valid;
    logic [1:0] ar_valid;
    logic [1:0] b_ready;
    logic [1:0] r_ready;
    wire  [1:0] aw_ready;
    wire  [1:0] w_ready;
    wire  [1:0] ar_ready;
    wire  [1:0] b_valid;
    wire  [1:0] r_valid;
    wire  [1:0] pending;  // Responses still owed per port

    processorci_top UUT (
        .sys_clk           (clk),
        .rst_i             (rst),
        .axi_i_aw_i        (aw[0]),
        .axi_i_aw_valid_i  (aw_valid[0]),
        .axi_i_aw_ready_o  (aw_ready[0]),
        .axi_i_w_i         (w[0]),
        .axi_i_w_valid_i   (w_valid[0]),
        .axi_i_w_ready_o   (w_ready[0]),
        .axi_i_b_o         (b[0]),
        .axi_i_b_valid_o   (b_valid[0]),
        .axi_i_b_ready_i   (b_ready[0]),
        .axi_i_ar_i        (ar[0]),
        .axi_i_ar_valid_i  (ar_valid[0]),
        .axi_i_ar_ready_o  (ar_ready[0]),
        .axi_i_r_o         (r[0]),
        .axi_i_r_valid_o   (r_valid[0]),
        .axi_i_r_ready_i   (r_ready[0]),
        .core_wb_req_o     (wb_req[0]),
        .core_wb_rsp_i     (wb_rsp[0]),
        .axi_d_aw_i        (aw[1]),
        .axi_d_aw_valid_i  (aw_valid[1]),
        .axi_d_aw_ready_o  (aw_ready[1]),
        .axi_d_w_i         (w[1]),
        .axi_d_w_valid_i   (w_valid[1]),
        .axi_d_w_ready_o   (w_ready[1]),
        .axi_d_b_o         (b[1]),
        .axi_d_b_valid_o   (b_valid[1]),
        .axi_d_b_ready_i   (b_ready[1]),
        .axi_d_ar_i        (ar[1]),
        .axi_d_ar_valid_i  (ar_valid[1]),
        .axi_d_ar_ready_o  (ar_ready[1]),
        .axi_d_r_o         (r[1]),
        .axi_d_r_valid_o   (r_valid[1]),
        .axi_d_r_ready_i   (r_ready[1]),
        .data_mem_wb_req_o (wb_req[1]),
        .data_mem_wb_rsp_i (wb_rsp[1])
    );

    wb_mem_model #(.WORDS(256), .SEED(SEED)) u_instr_mem (
        .clk      (clk),
        .rst_i    (rst),
        .wb_req_i (wb_req[0]),
        .wb_rsp_o (wb_rsp[0])
    );

    wb_mem_model #(.WORDS(256), .SEED(SEED)) u_data_mem (
        .clk      (clk),
        .rst_i    (rst),
        .wb_req_i (wb_req[1]),
        .wb_rsp_o (wb_rsp[1])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("Error: %s got 0x%0h expected 0x%0h", name, got, expected);
        stop_with_failure();
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_problem($sformatf("Timeout: run did not finish in %0d cycles", MAX_CYCLES));
        end
    end

    // Per port reference memory, response scoreboard and checks
    for (genvar p = 0; p < 2; p++) begin : g_port
        localparam string AXI = (p == 0) ? "axi_i" : "axi_d";
        localparam string WB  = (p == 0) ? "core_wb" : "data_mem_wb";

        logic [31:0] ref_mem [256];
        logic [3:0]  exp_bid [16];
        logic [3:0]  exp_rid [16];
        logic [31:0] exp_rdata [16];
        logic [3:0]  exp_sel;
        logic [3:0]  b_head = '0;
        logic [3:0]  b_tail = '0;
        logic [3:0]  b_acked = '0;  // Write acks seen on Wishbone
        logic [3:0]  r_head = '0;
        logic [3:0]  r_tail = '0;
        logic [3:0]  r_acked = '0;
        logic        rst_d = 1'b0;
        logic [6:0]  idle_flags;
        logic [5:0]  exp_b;
        logic [37:0] exp_r;

        assign idle_flags = {wb_req[p].cyc, wb_req[p].stb, aw_ready[p], w_ready[p],
                             ar_ready[p], b_valid[p], r_valid[p]};
        assign exp_b      = {exp_bid[b_head], 2'b00};  // OKAY
        assign exp_r      = {exp_rid[r_head], exp_rdata[r_head], 2'b00};
        assign pending[p] = (b_head != b_tail) || (r_head != r_tail);

        initial begin
            for (int a = 0; a < 256; a++) begin
                ref_mem[a] = {a[7:0], ~a[7:0], a[7:0] ^ 8'h3c, 8'hc3};
            end
        end

        // Acceptance order is Wishbone order, one transaction at a time
        always @(posedge clk) begin
            rst_d <= rst;
            if (aw_valid[p] && aw_ready[p]) begin
                exp_bid[b_tail] <= aw[p].id;
                exp_sel         <= w[p].strb;
                b_tail          <= b_tail + 1'b1;
                for (int i = 0; i < 4; i++) begin
                    if (w[p].strb[i]) begin
                        ref_mem[aw[p].addr[9:2]][8*i +: 8] <= w[p].data[8*i +: 8];
                    end
                end
            end
            if (ar_valid[p] && ar_ready[p]) begin
                exp_rid[r_tail]   <= ar[p].id;
                exp_rdata[r_tail] <= ref_mem[ar[p].addr[9:2]];
                r_tail            <= r_tail + 1'b1;
            end
            if (wb_req[p].stb && wb_rsp[p].ack) begin
                if (wb_req[p].we) begin
                    b_acked <= b_acked + 1'b1;
                end else begin
                    r_acked <= r_acked + 1'b1;
                end
            end
            if (b_valid[p] && b_ready[p]) begin
                b_head <= b_head + 1'b1;
            end
            if (r_valid[p] && r_ready[p]) begin
                r_head <= r_head + 1'b1;
            end
        end

        assert property (@(posedge clk) rst_d |-> idle_flags == '0)
            else report_mismatch($sformatf("%s idle flags", AXI), $sampled(idle_flags), 0);

        // W is taken in the same cycle as AW
        assert property (@(posedge clk) disable iff (rst) w_ready[p] == aw_ready[p])
            else report_mismatch($sformatf("%s_w_ready_o", AXI), $sampled(w_ready[p]),
                                 $sampled(aw_ready[p]));

        assert property (@(posedge clk) disable iff (rst)
                b_valid[p] && b_ready[p] |-> b_head != b_tail && b[p] == exp_b)
            else report_mismatch($sformatf("%s_b_o", AXI), $sampled(b[p]), $sampled(exp_b));

        assert property (@(posedge clk) disable iff (rst)
                r_valid[p] && r_ready[p] |-> r_head != r_tail && r[p] == exp_r)
            else report_mismatch($sformatf("%s_r_o", AXI), $sampled(r[p]), $sampled(exp_r));

        assert property (@(posedge clk) disable iff (rst)
                wb_req[p].stb && wb_req[p].we |-> wb_req[p].sel == exp_sel)
            else report_mismatch($sformatf("%s_req_o.sel", WB), $sampled(wb_req[p].sel),
                                 $sampled(exp_sel));

        assert property (@(posedge clk) disable iff (rst)
                wb_req[p].stb && !wb_rsp[p].ack |=> wb_req[p].stb && $stable(wb_req[p]))
            else report_problem($sformatf("%s: request dropped or changed before ack", WB));

        assert property (@(posedge clk) disable iff (rst)
                wb_req[p].stb && wb_rsp[p].ack |=> !wb_req[p].stb)
            else report_mismatch($sformatf("%s_req_o.stb", WB), 1, 0);

        assert property (@(posedge clk) disable iff (rst)
                4'(b_tail - b_head) <= 4'd2 && 4'(r_tail - r_head) <= 4'd2)
            else report_problem($sformatf("%s: over two requests taken with responses held", AXI));

        // No new cycle while its response FIFO is full
        assert property (@(posedge clk) disable iff (rst)
                $rose(wb_req[p].stb) |->
                (wb_req[p].we ? 4'(b_acked - b_head) : 4'(r_acked - r_head)) < 4'd2)
            else report_problem($sformatf("%s: stb rose with response FIFO full", WB));
    end

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic write_word(input int p, input logic [3:0] id, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
        aw[p]       = {id, addr};
        w[p]        = {data, strb};
        aw_valid[p] = 1'b1;
        w_valid[p]  = 1'b1;
        do begin
            @(negedge clk);
        end while (!aw_ready[p]);
        @(posedge clk);
        #1;
        aw_valid[p] = 1'b0;
        w_valid[p]  = 1'b0;
    endtask

    task automatic read_word(input int p, input logic [3:0] id, input logic [31:0] addr);
        ar[p]       = {id, addr};
        ar_valid[p] = 1'b1;
        do begin
            @(negedge clk);
        end while (!ar_ready[p]);
        @(posedge clk);
        #1;
        ar_valid[p] = 1'b0;
    endtask

    initial begin
        rst      = 1'b1;
        aw       = '{default: '0};
        w        = '{default: '0};
        ar       = '{default: '0};
        aw_valid = '0;
        w_valid  = '0;
        ar_valid = '0;
        b_ready  = 2'b11;
        r_ready  = 2'b11;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);  // Outputs must stay idle one cycle past reset
        #1;

        write_word(0, 4'h3, 32'h10, 32'hdead_beef, 4'hf);
        read_word(0, 4'h5, 32'h10);

        // Partial strobes merge into old words
        write_word(0, 4'h1, 32'h10, 32'h1122_3344, 4'b0101);
        write_word(0, 4'h2, 32'h14, 32'haabb_ccdd, 4'b1000);
        read_word(0, 4'h6, 32'h10);
        read_word(0, 4'h7, 32'h14);

        // Each port owns its memory
        write_word(1, 4'h9, 32'h10, 32'h0bad_f00d, 4'hf);
        read_word(0, 4'h8, 32'h10);
        write_word(0, 4'ha, 32'h20, 32'h1234_5678, 4'hf);
        read_word(1, 4'hb, 32'h20);
        read_word(1, 4'hc, 32'h10);

        // Write and read contend in the same cycle
        fork
            write_word(0, 4'hd, 32'h30, 32'hcafe_0001, 4'hf);
            read_word(0, 4'he, 32'h30);
        join

        // Responses held on the data port
        b_ready[1] = 1'b0;
        r_ready[1] = 1'b0;
        write_word(1, 4'h1, 32'h40, 32'h1111_0001, 4'hf);
        write_word(1, 4'h2, 32'h44, 32'h2222_0002, 4'b0011);
        fork
            write_word(1, 4'h3, 32'h48, 32'h3333_0003, 4'hf);
            begin
                repeat (12) @(posedge clk);
                #1;
                b_ready[1] = 1'b1;
            end
        join
        read_word(1, 4'h4, 32'h40);
        read_word(1, 4'h5, 32'h44);
        fork
            read_word(1, 4'h6, 32'h48);
            begin
                repeat (12) @(posedge clk);
                #1;
                r_ready[1] = 1'b1;
            end
        join

        while (pending != 2'b00) begin
            @(negedge clk);
        end
        @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/wb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
    parameter int WORDS = 256,
    parameter int SEED  = 36986
) (
    input  wire logic                     clk,
    input  wire logic                     rst_i,
    input  wire processorci_pkg::wb_req_t wb_req_i,
    output processorci_pkg::wb_rsp_t      wb_rsp_o
);

    localparam int IDX_W = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    logic [IDX_W-1:0] idx;
    logic             busy;       // Delay already drawn for this cycle
    int               wait_left;
    int               seed = SEED;

    assign idx = wb_req_i.addr[IDX_W+1:2];  // Word addressed

    // Fill varies with every address bit
    initial begin
        for (int a = 0; a < WORDS; a++) begin
            mem[a] = {a[7:0], ~a[7:0], a[7:0] ^ 8'h3c, 8'hc3};
        end
    end

    always @(posedge clk) begin
        wb_rsp_o.ack <= 1'b0;  // Single cycle ack
        if (rst_i) begin
            busy <= 1'b0;
        end else if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack) begin
            if (!busy) begin
                busy      <= 1'b1;
                wait_left <= $unsigned($random(seed)) % 4;  // 0 to 3 extra cycles
            end else if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                busy           <= 1'b0;
                wb_rsp_o.ack   <= 1'b1;
                wb_rsp_o.rdata <= mem[idx];
                if (wb_req_i.we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_req_i.sel[i]) begin
                            mem[idx][8*i +: 8] <= wb_req_i.wdata[8*i +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
